//--- vlog.f
source/tcu_fmt_pkg.sv
source/tcu_ctrl_pkg.sv
source/tcu_mul_unpack.sv
source/tcu_fedp.sv
source/tcu_beat_counter.sv
source/tcu_seq_fsm.sv
source/tcu_dot_top.sv
verification/tcu_dot_chk.sv
verification/tcu_dot_tb.sv

//--- Bender.yml
package:
  name: tcu_dot

sources:
  # Design sources, packages first
  - files:
      - source/tcu_fmt_pkg.sv
      - source/tcu_ctrl_pkg.sv
      - source/tcu_mul_unpack.sv
      - source/tcu_fedp.sv
      - source/tcu_beat_counter.sv
      - source/tcu_seq_fsm.sv
      - source/tcu_dot_top.sv

  # Testbench and bound checker
  - target: simulation
    files:
      - verification/tcu_dot_chk.sv
      - verification/tcu_dot_tb.sv

//--- verification/tcu_dot_tb.sv
`timescale 1ns/1ps

module tcu_dot_tb;

    localparam int N            = 2;
    localparam int LANES        = tcu_fmt_pkg::LANES_PER_WORD;
    localparam int MASK_W       = LANES * N;
    localparam int MAX_BEATS    = 16;
    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 10;
    localparam int DONE_TIMEOUT = 4 * tcu_ctrl_pkg::FEDP_LATENCY;
    localparam int NUM_TESTS    = 5;
    localparam int TOTAL_BEATS  = 4 + 1 + 16 + 16 + 16;
    localparam int MAX_GAP      = 3;
    localparam int WATCHDOG_NS  = (TOTAL_BEATS + 20 * NUM_TESTS) * CLK_PERIOD * 2;
    localparam int unsigned SEED = 32'h6d6eede5;

    typedef struct packed {
        tcu_fmt_pkg::word_t [N-1:0] a;
        tcu_fmt_pkg::word_t [N-1:0] b;
        logic [MASK_W-1:0]          mask;
    } beat_t;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       start;
    tcu_fmt_pkg::fmt_t          fmt;
    tcu_ctrl_pkg::beat_cnt_t    k_beats;
    logic                       beat_valid;
    tcu_fmt_pkg::word_t [N-1:0] a_row;
    tcu_fmt_pkg::word_t [N-1:0] b_col;
    logic [MASK_W-1:0]          sparse_mask;
    tcu_fmt_pkg::word_t         c_init;
    logic                       busy;
    logic                       done;
    tcu_fmt_pkg::word_t         d_val;

    beat_t       beats [MAX_BEATS];
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_ok = 0;

    tcu_dot_top #(
        .N (N)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .fmt         (fmt),
        .k_beats     (k_beats),
        .beat_valid  (beat_valid),
        .a_row       (a_row),
        .b_col       (b_col),
        .sparse_mask (sparse_mask),
        .c_init      (c_init),
        .busy        (busy),
        .done        (done),
        .d_val       (d_val)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("TB FAILED");
        $finish;
    end

    task automatic check_acc(input string what, input tcu_fmt_pkg::acc_t got,
                             input tcu_fmt_pkg::acc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input bit got, input bit exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", what, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // Sum of one beat's element products, wrapping like a 32-bit register
    function automatic tcu_fmt_pkg::acc_t beat_sum(input tcu_fmt_pkg::fmt_t f, input beat_t bt);
        int sum;
        int ea;
        int eb;
        sum = 0;
        for (int w = 0; w < N; w++) begin
            for (int l = 0; l < LANES; l++) begin
                if (f == tcu_fmt_pkg::FMT_INT16) begin
                    // Halves start on even lanes and use the even mask bits
                    if (l % 2 == 0 && bt.mask[LANES*w + l]) begin
                        ea = $signed(bt.a[w][8*l +: 16]);
                        eb = $signed(bt.b[w][8*l +: 16]);
                        sum = sum + ea * eb;
                    end
                end else if (bt.mask[LANES*w + l]) begin
                    if (f == tcu_fmt_pkg::FMT_UINT8) begin
                        ea = bt.a[w][8*l +: 8];
                        eb = bt.b[w][8*l +: 8];
                    end else begin
                        ea = $signed(bt.a[w][8*l +: 8]);
                        eb = $signed(bt.b[w][8*l +: 8]);
                    end
                    sum = sum + ea * eb;
                end
            end
        end
        return tcu_fmt_pkg::acc_t'(sum);
    endfunction

    function automatic tcu_fmt_pkg::acc_t model_run(input tcu_fmt_pkg::fmt_t f, input int k,
                                                    input tcu_fmt_pkg::word_t c);
        tcu_fmt_pkg::acc_t acc;
        acc = c;
        for (int i = 0; i < k; i++) begin
            acc = acc + beat_sum(f, beats[i]);
        end
        return acc;
    endfunction

    function automatic beat_t random_beat(input logic [MASK_W-1:0] mask);
        beat_t r;
        for (int w = 0; w < N; w++) begin
            r.a[w] = $urandom;
            r.b[w] = $urandom;
        end
        r.mask = mask;
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    task automatic start_run(input tcu_fmt_pkg::fmt_t f, input int k,
                             input tcu_fmt_pkg::word_t c);
        start   = 1'b1;
        fmt     = f;
        k_beats = tcu_ctrl_pkg::beat_cnt_t'(k);
        c_init  = c;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic apply_beat(input beat_t bt);
        a_row       = bt.a;
        b_col       = bt.b;
        sparse_mask = bt.mask;
        beat_valid  = 1'b1;
    endtask

    // Cycles are counted from the edge that samples the last beat, which counts as one
    task automatic wait_done(input int junk, inout int cycles);
        do begin
            next_cycle();
            cycles++;
            if (cycles <= junk) begin
                apply_beat(random_beat('1));
            end else begin
                beat_valid = 1'b0;
            end
        end while (!done && cycles < DONE_TIMEOUT);
        checks++;
        if (!done) begin
            report_problem($sformatf("done did not arrive within %0d cycles", cycles));
        end else if (cycles != tcu_ctrl_pkg::FEDP_LATENCY + 1) begin
            report_problem($sformatf("done came %0d cycles after the last beat, expected %0d",
                                     cycles, tcu_ctrl_pkg::FEDP_LATENCY + 1));
        end
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic run_dot(input tcu_fmt_pkg::fmt_t f, input int k, input tcu_fmt_pkg::word_t c,
                           input int max_gap, input int junk, output tcu_fmt_pkg::acc_t result);
        int cycles;
        start_run(f, k, c);
        for (int i = 0; i < k; i++) begin
            repeat ($urandom_range(max_gap, 0)) next_cycle();
            apply_beat(beats[i]);
            if (i < k - 1) begin
                next_cycle();
                beat_valid = 1'b0;
            end
        end
        cycles = 0;
        wait_done(junk, cycles);
        result = d_val;
    endtask

    task automatic control_protocol();
        int                 err0;
        int                 cycles;
        tcu_fmt_pkg::word_t c;
        tcu_fmt_pkg::acc_t  first_res;
        err0 = errors;
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_acc("d_val", d_val, '0);
        c = $urandom;
        for (int i = 0; i < 3; i++) begin
            beats[i] = random_beat('1);
        end
        start_run(tcu_fmt_pkg::FMT_INT8, 3, c);
        apply_beat(beats[0]);
        next_cycle();
        beat_valid = 1'b0;
        // Second start mid-run with another format and count
        start   = 1'b1;
        fmt     = tcu_fmt_pkg::FMT_UINT8;
        k_beats = 5'd1;
        next_cycle();
        start = 1'b0;
        check_flag("busy", busy, 1'b1);
        apply_beat(beats[1]);
        next_cycle();
        apply_beat(beats[2]);
        cycles = 0;
        wait_done(0, cycles);
        first_res = d_val;
        check_acc("d_val", first_res, model_run(tcu_fmt_pkg::FMT_INT8, 3, c));
        repeat (3) begin
            next_cycle();
            check_flag("done", done, 1'b0);
            check_acc("d_val", d_val, first_res);
        end
        // Old result stays visible while the next first beat is in flight
        c = $urandom;
        beats[0] = random_beat('1);
        start_run(tcu_fmt_pkg::FMT_INT16, 1, c);
        apply_beat(beats[0]);
        cycles = 0;
        repeat (tcu_ctrl_pkg::FEDP_LATENCY - 1) begin
            next_cycle();
            cycles++;
            beat_valid = 1'b0;
            check_acc("d_val", d_val, first_res);
        end
        wait_done(0, cycles);
        check_acc("d_val", d_val, model_run(tcu_fmt_pkg::FMT_INT16, 1, c));
        end_test("control_protocol", err0);
    endtask

    task automatic single_int16_run();
        int                 err0;
        tcu_fmt_pkg::word_t c;
        tcu_fmt_pkg::acc_t  res;
        err0 = errors;
        c = $urandom;
        beats[0] = random_beat('1);
        // Most negative and most positive halves in word 0
        beats[0].a[0] = 32'h8000_8000;
        beats[0].b[0] = 32'h8000_7fff;
        run_dot(tcu_fmt_pkg::FMT_INT16, 1, c, 0, 0, res);
        check_acc("d_val", res, model_run(tcu_fmt_pkg::FMT_INT16, 1, c));
        end_test("single_int16_run", err0);
    endtask

    task automatic int8_gap_run();
        int                 err0;
        tcu_fmt_pkg::word_t c;
        tcu_fmt_pkg::acc_t  res;
        err0 = errors;
        c = $urandom;
        for (int i = 0; i < MAX_BEATS; i++) begin
            beats[i] = random_beat('1);
        end
        run_dot(tcu_fmt_pkg::FMT_INT8, MAX_BEATS, c, MAX_GAP, 2, res);
        check_acc("d_val", res, model_run(tcu_fmt_pkg::FMT_INT8, MAX_BEATS, c));
        end_test("int8_gap_run", err0);
    endtask

    task automatic uint8_int8_pair();
        int                 err0;
        tcu_fmt_pkg::word_t c;
        tcu_fmt_pkg::acc_t  res;
        err0 = errors;
        c = $urandom;
        for (int i = 0; i < 8; i++) begin
            beats[i] = random_beat('1);
            for (int w = 0; w < N; w++) begin
                beats[i].a[w] = beats[i].a[w] | 32'h8000_0080;
                beats[i].b[w] = beats[i].b[w] | 32'h0080_8000;
            end
        end
        run_dot(tcu_fmt_pkg::FMT_INT8, 8, c, 1, 0, res);
        check_acc("d_val", res, model_run(tcu_fmt_pkg::FMT_INT8, 8, c));
        run_dot(tcu_fmt_pkg::FMT_UINT8, 8, c, 1, 0, res);
        check_acc("d_val", res, model_run(tcu_fmt_pkg::FMT_UINT8, 8, c));
        end_test("uint8_int8_pair", err0);
    endtask

    task automatic sparsity_masks();
        int                 err0;
        tcu_fmt_pkg::word_t c;
        tcu_fmt_pkg::acc_t  res;
        err0 = errors;
        c = $urandom;
        for (int i = 0; i < 8; i++) begin
            beats[i] = random_beat($urandom);
        end
        beats[0].mask = '0;
        run_dot(tcu_fmt_pkg::FMT_INT8, 8, c, 1, 0, res);
        check_acc("d_val", res, model_run(tcu_fmt_pkg::FMT_INT8, 8, c));
        for (int i = 0; i < 4; i++) begin
            beats[i] = random_beat($urandom);
        end
        run_dot(tcu_fmt_pkg::FMT_INT16, 4, c, 1, 0, res);
        check_acc("d_val", res, model_run(tcu_fmt_pkg::FMT_INT16, 4, c));
        // Nothing survives the mask, only c remains
        for (int i = 0; i < 4; i++) begin
            beats[i] = random_beat('0);
        end
        run_dot(tcu_fmt_pkg::FMT_UINT8, 4, c, 1, 0, res);
        check_acc("d_val", res, c);
        end_test("sparsity_masks", err0);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        start       = 1'b0;
        fmt         = tcu_fmt_pkg::FMT_INT16;
        k_beats     = 5'd1;
        beat_valid  = 1'b0;
        a_row       = '0;
        b_col       = '0;
        sparse_mask = '0;
        c_init      = '0;
        repeat (RESET_CYCLES) next_cycle();
        rst_n = 1'b1;
        next_cycle();
        control_protocol();
        single_int16_run();
        int8_gap_run();
        uint8_int8_pair();
        sparsity_masks();
        $display("Summary: %0d tests, %0d ok, %0d checks, %0d errors",
                 tests_run, tests_ok, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verification/tcu_dot_chk.sv
`timescale 1ns/1ps

module tcu_dot_chk (
    input logic                     clk,
    input logic                     rst_n,
    input tcu_ctrl_pkg::seq_state_e state,
    input logic                     busy,
    input logic                     done,
    input logic                     pipe_en
);

    // Done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) !(done && busy))
        else $error("done and busy were high together");

    // No pipeline movement while the sequencer sits in IDLE
    a_idle_no_pipe: assert property (@(posedge clk) disable iff (!rst_n)
        (state == tcu_ctrl_pkg::IDLE) |-> !pipe_en)
        else $error("pipeline enabled while the sequencer is idle");

endmodule

bind tcu_dot_top tcu_dot_chk u_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .state   (u_seq.state),
    .busy    (busy),
    .done    (done),
    .pipe_en (pipe_en)
);

//--- source/tcu_dot_top.sv
`timescale 1ns/1ps

module tcu_dot_top #(
    parameter int N = 2
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        start,
    input  tcu_fmt_pkg::fmt_t                           fmt,
    input  tcu_ctrl_pkg::beat_cnt_t                     k_beats,
    input  logic                                        beat_valid,
    input  tcu_fmt_pkg::word_t [N-1:0]                  a_row,
    input  tcu_fmt_pkg::word_t [N-1:0]                  b_col,
    input  logic [tcu_fmt_pkg::LANES_PER_WORD*N-1:0]    sparse_mask,
    input  tcu_fmt_pkg::word_t                          c_init,
    output logic                                        busy,
    output logic                                        done,
    output tcu_fmt_pkg::word_t                          d_val
);

    tcu_fmt_pkg::fmt_t       run_fmt;
    tcu_ctrl_pkg::beat_tag_t tag;
    logic                    load;
    logic                    beat_acc;
    logic                    drain_run;
    logic                    pipe_en;
    logic                    last_beat;
    logic                    drain_over;

    tcu_seq_fsm u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .fmt_in     (fmt),
        .beat_valid (beat_valid),
        .last_beat  (last_beat),
        .drain_over (drain_over),
        .fmt        (run_fmt),
        .tag        (tag),
        .load       (load),
        .beat_acc   (beat_acc),
        .drain_run  (drain_run),
        .pipe_en    (pipe_en),
        .busy       (busy),
        .done       (done)
    );

    tcu_beat_counter u_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .k_beats    (k_beats),
        .beat_acc   (beat_acc),
        .drain_run  (drain_run),
        .last_beat  (last_beat),
        .drain_over (drain_over)
    );

    // Accumulator output is the result port
    tcu_fedp #(
        .N (N)
    ) u_fedp (
        .clk         (clk),
        .rst_n       (rst_n),
        .pipe_en     (pipe_en),
        .fmt         (run_fmt),
        .tag         (tag),
        .a_row       (a_row),
        .b_col       (b_col),
        .sparse_mask (sparse_mask),
        .c_init      (c_init),
        .acc_out     (d_val)
    );

endmodule

//--- source/tcu_seq_fsm.sv
`timescale 1ns/1ps

module tcu_seq_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  tcu_fmt_pkg::fmt_t       fmt_in,
    input  logic                    beat_valid,
    input  logic                    last_beat,
    input  logic                    drain_over,
    output tcu_fmt_pkg::fmt_t       fmt,
    output tcu_ctrl_pkg::beat_tag_t tag,
    output logic                    load,
    output logic                    beat_acc,
    output logic                    drain_run,
    output logic                    pipe_en,
    output logic                    busy,
    output logic                    done
);

    tcu_ctrl_pkg::seq_state_e state;
    tcu_ctrl_pkg::seq_state_e state_nxt;
    logic                     start_ok;
    logic                     first_pend;

    // A new run may only begin once the previous one has finished
    assign start_ok = start
                   && (state == tcu_ctrl_pkg::IDLE || state == tcu_ctrl_pkg::DONE);
    assign beat_acc = beat_valid && (state == tcu_ctrl_pkg::RUN);
    assign load     = start_ok;

    always_comb begin
        state_nxt = state;
        case (state)
            tcu_ctrl_pkg::IDLE: begin
                if (start_ok) state_nxt = tcu_ctrl_pkg::RUN;
            end
            tcu_ctrl_pkg::RUN: begin
                if (beat_acc && last_beat) state_nxt = tcu_ctrl_pkg::DRAIN;
            end
            tcu_ctrl_pkg::DRAIN: begin
                if (drain_over) state_nxt = tcu_ctrl_pkg::DONE;
            end
            default: begin
                state_nxt = start_ok ? tcu_ctrl_pkg::RUN : tcu_ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= tcu_ctrl_pkg::IDLE;
            first_pend <= 1'b0;
        end else begin
            state <= state_nxt;
            if (start_ok) begin
                first_pend <= 1'b1;
            end else if (beat_acc) begin
                first_pend <= 1'b0;
            end
        end
    end

    // Format stays fixed for the whole run
    always_ff @(posedge clk) begin
        if (start_ok) begin
            fmt <= fmt_in;
        end
    end

    assign tag       = '{valid: beat_acc, first: beat_acc && first_pend};
    assign drain_run = (state == tcu_ctrl_pkg::DRAIN);
    assign busy      = (state == tcu_ctrl_pkg::RUN) || drain_run;
    assign pipe_en   = busy;
    assign done      = (state == tcu_ctrl_pkg::DONE);

endmodule

//--- source/tcu_beat_counter.sv
`timescale 1ns/1ps

module tcu_beat_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load,
    input  tcu_ctrl_pkg::beat_cnt_t k_beats,
    input  logic                    beat_acc,
    input  logic                    drain_run,
    output logic                    last_beat,
    output logic                    drain_over
);

    localparam int DRAIN_W = $clog2(tcu_ctrl_pkg::FEDP_LATENCY);

    tcu_ctrl_pkg::beat_cnt_t remaining;
    logic [DRAIN_W-1:0]      drain_cnt;

    // Beats still expected in this run
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= k_beats;
        end else if (beat_acc && remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // A zero count behaves like a single beat
    assign last_beat = (remaining <= 5'd1);

    // Cycles spent flushing the pipeline after the last beat
    always_ff @(posedge clk) begin
        if (!rst_n || !drain_run) begin
            drain_cnt <= '0;
        end else begin
            drain_cnt <= drain_cnt + 1'b1;
        end
    end

    assign drain_over = drain_run
                     && (drain_cnt == DRAIN_W'(tcu_ctrl_pkg::FEDP_LATENCY - 1));

endmodule

//--- source/tcu_fedp.sv
`timescale 1ns/1ps

module tcu_fedp #(
    parameter int N = 2
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        pipe_en,
    input  tcu_fmt_pkg::fmt_t                           fmt,
    input  tcu_ctrl_pkg::beat_tag_t                     tag,
    input  tcu_fmt_pkg::word_t [N-1:0]                  a_row,
    input  tcu_fmt_pkg::word_t [N-1:0]                  b_col,
    input  logic [tcu_fmt_pkg::LANES_PER_WORD*N-1:0]    sparse_mask,
    input  tcu_fmt_pkg::word_t                          c_init,
    output tcu_fmt_pkg::acc_t                           acc_out
);

    localparam int SLOTS = tcu_fmt_pkg::LANES_PER_WORD * N;
    localparam int PAIRS = SLOTS / 2;
    localparam int LAST  = tcu_ctrl_pkg::FEDP_LATENCY - 1;

    tcu_fmt_pkg::prod_t [SLOTS-1:0] prod_c;
    tcu_fmt_pkg::prod_t [SLOTS-1:0] prod_q;
    logic [SLOTS-1:0]               mask_q;
    tcu_fmt_pkg::word_t             c_s1;
    tcu_fmt_pkg::word_t             c_s2;
    tcu_fmt_pkg::acc_t [PAIRS-1:0]  pair_c;
    tcu_fmt_pkg::acc_t [PAIRS-1:0]  pair_q;
    tcu_fmt_pkg::acc_t              tree_c;
    tcu_fmt_pkg::acc_t              sum_q;
    tcu_fmt_pkg::acc_t              acc_q;
    // tag_q[s] lines up with the data held in stage s
    tcu_ctrl_pkg::beat_tag_t        tag_q [1:LAST];

    tcu_mul_unpack #(
        .N (N)
    ) u_mul (
        .fmt         (fmt),
        .a_row       (a_row),
        .b_col       (b_col),
        .sparse_mask (sparse_mask),
        .products    (prod_c)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 1; s <= LAST; s++) begin
                tag_q[s] <= '0;
            end
        end else if (pipe_en) begin
            tag_q[1] <= tag;
            for (int s = 2; s <= LAST; s++) begin
                tag_q[s] <= tag_q[s-1];
            end
        end
    end

    // Stage 1, product registers only load for lanes the mask keeps
    always_ff @(posedge clk) begin
        if (pipe_en) begin
            mask_q <= sparse_mask;
            c_s1   <= c_init;
            for (int i = 0; i < SLOTS; i++) begin
                if (sparse_mask[i]) begin
                    prod_q[i] <= prod_c[i];
                end
            end
        end
    end

    // Stage 2, first tree level; held registers of pruned lanes read as zero
    always_comb begin
        for (int p = 0; p < PAIRS; p++) begin
            pair_c[p] = (mask_q[2*p]   ? prod_q[2*p]   : '0)
                      + (mask_q[2*p+1] ? prod_q[2*p+1] : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_en) begin
            pair_q <= pair_c;
            c_s2   <= c_s1;
        end
    end

    // Stage 3, rest of the tree plus c on the opening beat
    always_comb begin
        tree_c = tag_q[2].first ? c_s2 : '0;
        for (int p = 0; p < PAIRS; p++) begin
            tree_c = tree_c + pair_q[p];
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_en) begin
            sum_q <= tree_c;
        end
    end

    // Stage 4, accumulator holds across bubbles and idle time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (pipe_en && tag_q[LAST].valid) begin
            if (tag_q[LAST].first) begin
                acc_q <= sum_q;
            end else begin
                acc_q <= acc_q + sum_q;
            end
        end
    end

    assign acc_out = acc_q;

endmodule

//--- source/tcu_mul_unpack.sv
`timescale 1ns/1ps

module tcu_mul_unpack #(
    parameter int N = 2
) (
    input  tcu_fmt_pkg::fmt_t                                     fmt,
    input  tcu_fmt_pkg::word_t [N-1:0]                            a_row,
    input  tcu_fmt_pkg::word_t [N-1:0]                            b_col,
    input  logic [tcu_fmt_pkg::LANES_PER_WORD*N-1:0]              sparse_mask,
    output tcu_fmt_pkg::prod_t [tcu_fmt_pkg::LANES_PER_WORD*N-1:0] products
);

    localparam int LANES = tcu_fmt_pkg::LANES_PER_WORD;

    for (genvar w = 0; w < N; w++) begin : g_word
        for (genvar l = 0; l < LANES; l++) begin : g_lane
            localparam int SLOT = w * LANES + l;

            logic [15:0]        a_half;
            logic [15:0]        b_half;
            logic [7:0]         a_byte;
            logic [7:0]         b_byte;
            logic signed [16:0] a_el;
            logic signed [16:0] b_el;
            logic signed [33:0] prod_full;

            // Half word feeding this slot in int16 mode, even lanes only use it
            assign a_half = a_row[w][16*(l/2) +: 16];
            assign b_half = b_col[w][16*(l/2) +: 16];
            assign a_byte = a_row[w][8*l +: 8];
            assign b_byte = b_col[w][8*l +: 8];

            always_comb begin
                case (fmt)
                    tcu_fmt_pkg::FMT_INT16: begin
                        if ((l % 2) == 0) begin
                            a_el = {a_half[15], a_half};
                            b_el = {b_half[15], b_half};
                        end else begin
                            // Odd slots carry nothing with 16-bit elements
                            a_el = '0;
                            b_el = '0;
                        end
                    end
                    tcu_fmt_pkg::FMT_UINT8: begin
                        a_el = {9'd0, a_byte};
                        b_el = {9'd0, b_byte};
                    end
                    default: begin
                        a_el = {{9{a_byte[7]}}, a_byte};
                        b_el = {{9{b_byte[7]}}, b_byte};
                    end
                endcase
            end

            assign prod_full = a_el * b_el;

            // Pruned elements contribute nothing
            assign products[SLOT] = sparse_mask[SLOT] ? prod_full[31:0] : '0;
        end
    end

endmodule

//--- source/tcu_ctrl_pkg.sv
package tcu_ctrl_pkg;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2,
        DONE  = 2'd3
    } seq_state_e;

    // Beats per dot product, 1 to 16
    typedef logic [4:0] beat_cnt_t;

    // Register stages in the fused dot-product pipeline
    localparam int FEDP_LATENCY = 4;

    // Per-beat tag carried alongside the data through every stage
    typedef struct packed {
        // Beat carries data, otherwise a bubble
        logic valid;
        // Restart the accumulator and add c_init
        logic first;
    } beat_tag_t;

endpackage

//--- source/tcu_fmt_pkg.sv
package tcu_fmt_pkg;

    // Operand and result word as seen on the ports
    typedef logic [31:0] word_t;

    // Element format selector
    typedef logic [1:0] fmt_t;

    // Code 3 decodes like FMT_INT8
    localparam fmt_t FMT_INT16 = 2'd0;
    localparam fmt_t FMT_INT8  = 2'd1;
    localparam fmt_t FMT_UINT8 = 2'd2;

    // Product of one element pair
    // int16 x int16 still fits in 32 signed bits
    typedef logic signed [31:0] prod_t;

    // Running dot-product sum, wraps modulo 2^32
    typedef logic [31:0] acc_t;

    // Byte lanes in one word, one sparsity mask bit each
    localparam int LANES_PER_WORD = 4;

endpackage
